// File: vec_consts.svh
// sizing constants for the vector lane
// VEC_VLEN must equal VEC_ELEN * VEC_NELEM, nothing checks this
// VEC_NREGS and VEC_MAX_GROUP must be powers of two, so indices wrap

`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// bits per vector register
`define VEC_VLEN 64

// bits per element
`define VEC_ELEN 8

// elements per register, also the mask width
`define VEC_NELEM 8

// architectural registers, v0 doubles as the mask
`define VEC_NREGS 16

// write ports into the register file, ALU and load port
`define VEC_NWB 2

// longest register group one instruction can cover
`define VEC_MAX_GROUP 4

`endif

// File: vec_pkg.sv
// shared types for the vector lane
// widths are derived from the constants header
// vgroup_t holds group length minus one

`include "vec_consts.svh"

package vec_pkg;

    // register index, wraps modulo VEC_NREGS
    typedef logic [$clog2(`VEC_NREGS)-1:0] vreg_addr_t;

    // whole register and single element
    typedef logic [`VEC_VLEN-1:0] vreg_data_t;
    typedef logic [`VEC_ELEN-1:0] velem_t;

    // one bit per element
    typedef logic [`VEC_NELEM-1:0] vmask_t;

    // offset within a group, also length minus one
    typedef logic [$clog2(`VEC_MAX_GROUP)-1:0] vgroup_t;

    // element-wise opcodes, arithmetic wraps per element
    typedef enum logic [2:0] {
        VADD  = 3'd0,
        VSUB  = 3'd1,
        VAND  = 3'd2,
        VOR   = 3'd3,
        VXOR  = 3'd4,
        VMINU = 3'd5,
        VMAXU = 3'd6
    } vec_op_e;

    // sequencer states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_EXEC = 2'd1,
        ST_DONE = 2'd2
    } vec_state_e;

endpackage

// File: vec_ctrl_if.sv
// per-cycle execute command from the sequencer to the datapath
// addresses already include the group offset
// exec_valid low means nothing is written through port 0

`timescale 1ns/1ps

interface vec_ctrl_if;

    import vec_pkg::*;

    logic       exec_valid;
    vreg_addr_t vd_addr;
    vreg_addr_t vs1_addr;
    vreg_addr_t vs2_addr;
    vec_op_e    op;
    logic       masked;

    // sequencer side drives the command
    modport sequencer (
        output exec_valid, vd_addr, vs1_addr, vs2_addr, op, masked
    );

    // datapath side only consumes it
    modport datapath (
        input exec_valid, vd_addr, vs1_addr, vs2_addr, op, masked
    );

endinterface

// File: vec_regfile.sv
// vector register file, VEC_NWB write ports and four read ports
// every read port sees a same-cycle load through the bypass
// mask always comes from v0, low VEC_NELEM bits
// the two write ports must not target the same register in one cycle

`timescale 1ns/1ps

`include "vec_consts.svh"

module vec_regfile (
    input  logic                                 clk_i,
    input  logic                                 rstn_i,
    // write ports
    input  logic                   [`VEC_NWB-1:0] write_enable_i,
    input  vec_pkg::vreg_addr_t    [`VEC_NWB-1:0] write_addr_i,
    input  vec_pkg::vreg_data_t    [`VEC_NWB-1:0] write_data_i,
    // read ports
    input  vec_pkg::vreg_addr_t                   read_addr1_i,
    input  vec_pkg::vreg_addr_t                   read_addr2_i,
    input  vec_pkg::vreg_addr_t                   read_addr_old_vd_i,
    input  logic                                  use_mask_i,
    output vec_pkg::vreg_data_t                   read_data1_o,
    output vec_pkg::vreg_data_t                   read_data2_o,
    output vec_pkg::vreg_data_t                   read_data_old_vd_o,
    output vec_pkg::vmask_t                       read_mask_o
);

    import vec_pkg::*;

    localparam vreg_addr_t MASK_REG = '0;

    vreg_data_t regs_q [`VEC_NREGS];
    vreg_data_t mask_reg;

    // storage value, overridden by a same-cycle load to the same index
    // port 0 carries the ALU result built from these reads, so it is not bypassed
    function automatic vreg_data_t bypass_read(input vreg_addr_t addr);
        vreg_data_t data;
        data = regs_q[addr];
        for (int i = 1; i < `VEC_NWB; i++) begin
            if (write_enable_i[i] && (write_addr_i[i] == addr)) begin
                data = write_data_i[i];
            end
        end
        return data;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        read_data1_o       = bypass_read(read_addr1_i);
        read_data2_o       = bypass_read(read_addr2_i);
        read_data_old_vd_o = bypass_read(read_addr_old_vd_i);
        mask_reg           = bypass_read(MASK_REG);
    end

    // unmasked ops see every element enabled
    assign read_mask_o = use_mask_i ? mask_reg[`VEC_NELEM-1:0] : '1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int r = 0; r < `VEC_NREGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int i = 0; i < `VEC_NWB; i++) begin
                if (write_enable_i[i]) begin
                    regs_q[write_addr_i[i]] <= write_data_i[i];
                end
            end
        end
    end

    // the sequencer stalls on a load hazard, so ALU and load port never collide
    property p_no_write_collision;
        @(posedge clk_i) disable iff (!rstn_i)
        !(write_enable_i[0] && write_enable_i[1] &&
          (write_addr_i[0] == write_addr_i[1]));
    endproperty

    a_no_write_collision: assert property (p_no_write_collision)
        else $error("write ports 0 and 1 hit the same register");

endmodule

// File: vec_alu.sv
// element-wise vector ALU, purely combinational
// operand order is src2 op src1, so VSUB gives src2 - src1
// masked-off elements keep the old destination value

`timescale 1ns/1ps

`include "vec_consts.svh"

module vec_alu (
    input  vec_pkg::vec_op_e    op_i,
    input  vec_pkg::vreg_data_t src1_i,
    input  vec_pkg::vreg_data_t src2_i,
    input  vec_pkg::vreg_data_t old_vd_i,
    input  vec_pkg::vmask_t     mask_i,
    output vec_pkg::vreg_data_t result_o
);

    import vec_pkg::*;

    // one element of the operation, wraps modulo 2^ELEN
    function automatic velem_t elem_op(input vec_op_e op,
                                       input velem_t  a,
                                       input velem_t  b);
        velem_t r;
        case (op)
            VADD:    r = a + b;
            VSUB:    r = a - b;
            VAND:    r = a & b;
            VOR:     r = a | b;
            VXOR:    r = a ^ b;
            VMINU:   r = (a < b) ? a : b;
            VMAXU:   r = (a > b) ? a : b;
            default: r = '0;
        endcase
        return r;
    endfunction

    always_comb begin
        velem_t e1;
        velem_t e2;
        velem_t eo;
        result_o = '0;
        for (int e = 0; e < `VEC_NELEM; e++) begin
            e1 = src1_i[e*`VEC_ELEN +: `VEC_ELEN];
            e2 = src2_i[e*`VEC_ELEN +: `VEC_ELEN];
            eo = old_vd_i[e*`VEC_ELEN +: `VEC_ELEN];
            // merge under the mask
            if (mask_i[e]) begin
                result_o[e*`VEC_ELEN +: `VEC_ELEN] = elem_op(op_i, e2, e1);
            end else begin
                result_o[e*`VEC_ELEN +: `VEC_ELEN] = eo;
            end
        end
    end

endmodule

// File: vec_group_counter.sv
// offset of the current register inside a group
// load_i wins over step_i, stepping past the length is not allowed

`timescale 1ns/1ps

module vec_group_counter (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             load_i,
    input  vec_pkg::vgroup_t length_i,
    input  logic             step_i,
    output vec_pkg::vgroup_t offset_o,
    output logic             last_o
);

    import vec_pkg::*;

    vgroup_t offset_q;
    vgroup_t length_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            offset_q <= '0;
            length_q <= '0;
        end else if (load_i) begin
            offset_q <= '0;
            length_q <= length_i;
        end else if (step_i) begin
            offset_q <= offset_q + 1'b1;
        end
    end

    assign offset_o = offset_q;
    assign last_o   = (offset_q == length_q);

    // the sequencer must stop stepping once last_o is reached
    a_offset_in_range: assert property (
        @(posedge clk_i) disable iff (!rstn_i) offset_q <= length_q
    ) else $error("group offset ran past the latched length");

endmodule

// File: vec_issue_fsm.sv
// issue sequencer, one register of the group per execute cycle
// a load to the current destination stalls that cycle, the op is redone
// issues seen while busy_o is high are dropped without notice

`timescale 1ns/1ps

module vec_issue_fsm (
    input  logic                clk_i,
    input  logic                rstn_i,
    // issue strobe and instruction
    input  logic                issue_valid_i,
    input  vec_pkg::vec_op_e    issue_op_i,
    input  vec_pkg::vreg_addr_t issue_vd_i,
    input  vec_pkg::vreg_addr_t issue_vs1_i,
    input  vec_pkg::vreg_addr_t issue_vs2_i,
    input  vec_pkg::vgroup_t    issue_group_i,
    input  logic                issue_masked_i,
    // load port, for hazard detection only
    input  logic                ld_we_i,
    input  vec_pkg::vreg_addr_t ld_addr_i,
    // group counter
    input  vec_pkg::vgroup_t    offset_i,
    input  logic                last_i,
    output logic                cnt_load_o,
    output vec_pkg::vgroup_t    cnt_length_o,
    output logic                cnt_step_o,
    // status
    output logic                busy_o,
    output logic                done_o,
    vec_ctrl_if.sequencer       ctrl
);

    import vec_pkg::*;

    vec_state_e state_q;
    vec_state_e state_d;
    logic       accept;
    logic       hazard;
    vreg_addr_t vd_cur;

    // latched instruction
    vec_op_e    op_q;
    vreg_addr_t vd_q;
    vreg_addr_t vs1_q;
    vreg_addr_t vs2_q;
    logic       masked_q;

    assign accept = (state_q == ST_IDLE) && issue_valid_i;

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q     <= issue_op_i;
            vd_q     <= issue_vd_i;
            vs1_q    <= issue_vs1_i;
            vs2_q    <= issue_vs2_i;
            masked_q <= issue_masked_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (accept) state_d = ST_EXEC;
            ST_EXEC: if (ctrl.exec_valid && last_i) state_d = ST_DONE;
            ST_DONE: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // base plus offset, wraps at the top of the file
    assign vd_cur = vd_q + vreg_addr_t'(offset_i);
    assign hazard = ld_we_i && (ld_addr_i == vd_cur);

    assign ctrl.exec_valid = (state_q == ST_EXEC) && !hazard;
    assign ctrl.vd_addr    = vd_cur;
    assign ctrl.vs1_addr   = vs1_q + vreg_addr_t'(offset_i);
    assign ctrl.vs2_addr   = vs2_q + vreg_addr_t'(offset_i);
    assign ctrl.op         = op_q;
    assign ctrl.masked     = masked_q;

    // counter moves only on a real write, never past the last register
    assign cnt_load_o   = accept;
    assign cnt_length_o = issue_group_i;
    assign cnt_step_o   = ctrl.exec_valid && !last_i;

    assign busy_o = (state_q != ST_IDLE);
    assign done_o = (state_q == ST_DONE);

    a_done_single: assert property (
        @(posedge clk_i) disable iff (!rstn_i) done_o |=> !done_o
    ) else $error("done_o held for more than one cycle");

endmodule

// File: vec_unit_top.sv
// vector lane top, plain strobe ports only
// rd_data_o is valid while idle and reads zero while busy
// ld_* may write at any time, a hit on the destination stalls execution

`timescale 1ns/1ps

`include "vec_consts.svh"

module vec_unit_top (
    input  logic                clk_i,
    input  logic                rstn_i,
    // issue
    input  logic                issue_valid_i,
    input  vec_pkg::vec_op_e    issue_op_i,
    input  vec_pkg::vreg_addr_t issue_vd_i,
    input  vec_pkg::vreg_addr_t issue_vs1_i,
    input  vec_pkg::vreg_addr_t issue_vs2_i,
    input  vec_pkg::vgroup_t    issue_group_i,
    input  logic                issue_masked_i,
    output logic                busy_o,
    output logic                done_o,
    // load port
    input  logic                ld_we_i,
    input  vec_pkg::vreg_addr_t ld_addr_i,
    input  vec_pkg::vreg_data_t ld_data_i,
    // read-back
    input  vec_pkg::vreg_addr_t rd_addr_i,
    output vec_pkg::vreg_data_t rd_data_o
);

    import vec_pkg::*;

    vec_ctrl_if ctrl ();

    vgroup_t    offset;
    vgroup_t    cnt_length;
    logic       last;
    logic       cnt_load;
    logic       cnt_step;
    vreg_addr_t read_addr1;
    vreg_data_t src1;
    vreg_data_t src2;
    vreg_data_t old_vd;
    vmask_t     mask;
    vreg_data_t alu_result;

    logic       [`VEC_NWB-1:0] wr_en;
    vreg_addr_t [`VEC_NWB-1:0] wr_addr;
    vreg_data_t [`VEC_NWB-1:0] wr_data;

    vec_issue_fsm u_fsm (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .issue_valid_i  (issue_valid_i),
        .issue_op_i     (issue_op_i),
        .issue_vd_i     (issue_vd_i),
        .issue_vs1_i    (issue_vs1_i),
        .issue_vs2_i    (issue_vs2_i),
        .issue_group_i  (issue_group_i),
        .issue_masked_i (issue_masked_i),
        .ld_we_i        (ld_we_i),
        .ld_addr_i      (ld_addr_i),
        .offset_i       (offset),
        .last_i         (last),
        .cnt_load_o     (cnt_load),
        .cnt_length_o   (cnt_length),
        .cnt_step_o     (cnt_step),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .ctrl           (ctrl.sequencer)
    );

    vec_group_counter u_cnt (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .load_i   (cnt_load),
        .length_i (cnt_length),
        .step_i   (cnt_step),
        .offset_o (offset),
        .last_o   (last)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath wiring
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // port 1 serves read-back only while idle
    assign read_addr1 = busy_o ? ctrl.vs1_addr : rd_addr_i;
    assign rd_data_o  = busy_o ? '0 : src1;

    // port 0 from the ALU, port 1 from the load port
    assign wr_en   = {ld_we_i, ctrl.exec_valid};
    assign wr_addr = {ld_addr_i, ctrl.vd_addr};
    assign wr_data = {ld_data_i, alu_result};

    vec_regfile u_rf (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .write_enable_i     (wr_en),
        .write_addr_i       (wr_addr),
        .write_data_i       (wr_data),
        .read_addr1_i       (read_addr1),
        .read_addr2_i       (ctrl.vs2_addr),
        .read_addr_old_vd_i (ctrl.vd_addr),
        .use_mask_i         (ctrl.masked),
        .read_data1_o       (src1),
        .read_data2_o       (src2),
        .read_data_old_vd_o (old_vd),
        .read_mask_o        (mask)
    );

    vec_alu u_alu (
        .op_i     (ctrl.op),
        .src1_i   (src1),
        .src2_i   (src2),
        .old_vd_i (old_vd),
        .mask_i   (mask),
        .result_o (alu_result)
    );

endmodule

// File: tb_clkgen.sv
// clock and reset source for the testbench
// reset is active low and released on a rising edge

`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

// File: tb_vec_unit.sv
// self-checking testbench for the vector lane, xorshift stimulus, fixed seed
// the model steps one cycle per falling edge, using the inputs driven at the rising edge
// during load hazard tests busy_o, done_o and rd_data_o are not compared per cycle

`timescale 1ns/1ps

`include "vec_consts.svh"

module tb_vec_unit;

    import vec_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int OP_TIMEOUT   = 20;
    localparam int N_RESET      = `VEC_NREGS;
    localparam int N_LOADS      = 40;
    localparam int N_UNMASKED   = 12;
    localparam int N_MASKED     = 12;
    localparam int N_HAZARD     = 8;
    localparam int N_BUSY       = 6;
    localparam int NUM_TESTS    = N_RESET + N_LOADS + N_UNMASKED + N_MASKED + N_HAZARD + N_BUSY;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 20 + RESET_CYCLES;

    logic       clk;
    logic       rstn;
    logic       issue_valid;
    vec_op_e    issue_op;
    vreg_addr_t issue_vd;
    vreg_addr_t issue_vs1;
    vreg_addr_t issue_vs2;
    vgroup_t    issue_group;
    logic       issue_masked;
    logic       busy;
    logic       done;
    logic       ld_we;
    vreg_addr_t ld_addr;
    vreg_data_t ld_data;
    vreg_addr_t rd_addr;
    vreg_data_t rd_data;

    // reference model state
    vreg_data_t model_regs [`VEC_NREGS];
    vec_state_e model_state;
    vgroup_t    m_offset;
    vgroup_t    m_group;
    vec_op_e    m_op;
    vreg_addr_t m_vd;
    vreg_addr_t m_vs1;
    vreg_addr_t m_vs2;
    logic       m_masked;

    logic [31:0] rand_state;
    bit          strict_timing;
    int          check_count;
    int          error_count;

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    vec_unit_top u_dut (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .issue_valid_i  (issue_valid),
        .issue_op_i     (issue_op),
        .issue_vd_i     (issue_vd),
        .issue_vs1_i    (issue_vs1),
        .issue_vs2_i    (issue_vs2),
        .issue_group_i  (issue_group),
        .issue_masked_i (issue_masked),
        .busy_o         (busy),
        .done_o         (done),
        .ld_we_i        (ld_we),
        .ld_addr_i      (ld_addr),
        .ld_data_i      (ld_data),
        .rd_addr_i      (rd_addr),
        .rd_data_o      (rd_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random numbers and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_random();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    function automatic vec_op_e random_op();
        logic [31:0] r;
        r = next_random();
        return vec_op_e'(3'(r % 7));
    endfunction

    // per element src2 op src1, old element kept where the mask bit is clear
    function automatic vreg_data_t expected_result(input vec_op_e op, input vreg_data_t s1,
                                                   input vreg_data_t s2, input vreg_data_t old,
                                                   input vmask_t mask);
        vreg_data_t res;
        velem_t     a;
        velem_t     b;
        velem_t     y;
        res = old;
        for (int e = 0; e < `VEC_NELEM; e++) begin
            a = s2[e*`VEC_ELEN +: `VEC_ELEN];
            b = s1[e*`VEC_ELEN +: `VEC_ELEN];
            case (op)
                VADD:    y = a + b;
                VSUB:    y = a - b;
                VAND:    y = a & b;
                VOR:     y = a | b;
                VXOR:    y = a ^ b;
                VMINU:   y = (a < b) ? a : b;
                VMAXU:   y = (a > b) ? a : b;
                default: y = '0;
            endcase
            if (mask[e]) res[e*`VEC_ELEN +: `VEC_ELEN] = y;
        end
        return res;
    endfunction

    // read-back value while idle, same-cycle load wins
    function automatic vreg_data_t expected_readback(input vreg_addr_t addr);
        if (ld_we && (ld_addr == addr)) return ld_data;
        return model_regs[addr];
    endfunction

    task automatic compare_reg(input string name, input vreg_data_t got, input vreg_data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // compare outputs mid-cycle, then move the model past the next edge
    task automatic check_and_advance();
        vreg_addr_t cur_vd;
        vreg_addr_t s1_idx;
        vreg_addr_t s2_idx;
        vmask_t     mask;
        logic       hazard;
        @(negedge clk);
        if (strict_timing) begin
            compare_flag("busy_o", busy, model_state != ST_IDLE);
            compare_flag("done_o", done, model_state == ST_DONE);
            compare_reg("rd_data_o", rd_data,
                        (model_state == ST_IDLE) ? expected_readback(rd_addr) : '0);
        end
        cur_vd = m_vd + vreg_addr_t'(m_offset);
        s1_idx = m_vs1 + vreg_addr_t'(m_offset);
        s2_idx = m_vs2 + vreg_addr_t'(m_offset);
        hazard = ld_we && (ld_addr == cur_vd);
        // the load lands before the op reads
        if (ld_we) model_regs[ld_addr] = ld_data;
        case (model_state)
            ST_IDLE: begin
                if (issue_valid) begin
                    m_op        = issue_op;
                    m_vd        = issue_vd;
                    m_vs1       = issue_vs1;
                    m_vs2       = issue_vs2;
                    m_group     = issue_group;
                    m_masked    = issue_masked;
                    m_offset    = '0;
                    model_state = ST_EXEC;
                end
            end
            ST_EXEC: begin
                if (!hazard) begin
                    mask = m_masked ? model_regs[0][`VEC_NELEM-1:0] : '1;
                    model_regs[cur_vd] = expected_result(m_op, model_regs[s1_idx],
                                                         model_regs[s2_idx],
                                                         model_regs[cur_vd], mask);
                    if (m_offset == m_group) model_state = ST_DONE;
                    else m_offset = m_offset + 1'b1;
                end
            end
            default: model_state = ST_IDLE;
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_idle(input logic we, input vreg_addr_t la, input vreg_data_t ld,
                              input vreg_addr_t ra);
        @(posedge clk);
        issue_valid <= 1'b0;
        ld_we       <= we;
        ld_addr     <= la;
        ld_data     <= ld;
        rd_addr     <= ra;
        check_and_advance();
    endtask

    task automatic read_group(input vreg_addr_t base, input vgroup_t grp);
        for (int k = 0; k <= int'(grp); k++) begin
            drive_idle(1'b0, '0, '0, base + vreg_addr_t'(k));
        end
    endtask

    task automatic run_op(input vec_op_e op, input vreg_addr_t vd, input vreg_addr_t vs1,
                          input vreg_addr_t vs2, input vgroup_t grp, input logic msk,
                          input bit with_loads, input bit busy_issues);
        logic [31:0] r;
        int          cycles;
        int          loads_left;
        bit          seen_done;
        @(posedge clk);
        issue_valid  <= 1'b1;
        issue_op     <= op;
        issue_vd     <= vd;
        issue_vs1    <= vs1;
        issue_vs2    <= vs2;
        issue_group  <= grp;
        issue_masked <= msk;
        ld_we        <= 1'b0;
        rd_addr      <= '0;
        check_and_advance();
        strict_timing = !with_loads;
        cycles     = 0;
        loads_left = 4;
        seen_done  = 1'b0;
        while (!seen_done && (cycles < OP_TIMEOUT)) begin
            r = next_random();
            @(posedge clk);
            issue_valid <= busy_issues;
            if (busy_issues) begin
                issue_op    <= random_op();
                issue_vd    <= r[3:0];
                issue_group <= r[5:4];
            end
            // loads near the group, some hit the destination being written
            ld_we <= 1'b0;
            if (with_loads && (loads_left > 0) && r[7]) begin
                loads_left--;
                ld_we   <= 1'b1;
                ld_addr <= vd + vreg_addr_t'(r[9:8]);
                ld_data <= {next_random(), next_random()};
            end
            check_and_advance();
            seen_done = done;
            cycles++;
        end
        strict_timing = 1'b1;
        if (!seen_done) begin
            error_count++;
            $display("done_o did not arrive within %0d cycles of the issue", OP_TIMEOUT);
        end
    endtask

    task automatic report_test(input string name, input int items, input int errors_before);
        $display("test %-16s %0d items, %0d errors", name, items, error_count - errors_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] r;
        vreg_addr_t  vd;
        vgroup_t     grp;
        int          errs;
        issue_valid   = 1'b0;
        issue_op      = VADD;
        issue_vd      = '0;
        issue_vs1     = '0;
        issue_vs2     = '0;
        issue_group   = '0;
        issue_masked  = 1'b0;
        ld_we         = 1'b0;
        ld_addr       = '0;
        ld_data       = '0;
        rd_addr       = '0;
        rand_state    = 32'd67823;
        strict_timing = 1'b1;
        check_count   = 0;
        error_count   = 0;
        model_state   = ST_IDLE;
        m_offset      = '0;
        m_group       = '0;
        m_op          = VADD;
        m_vd          = '0;
        m_vs1         = '0;
        m_vs2         = '0;
        m_masked      = 1'b0;
        for (int i = 0; i < `VEC_NREGS; i++) model_regs[i] = '0;
        wait (rstn == 1'b1);

        errs = error_count;
        for (int i = 0; i < N_RESET; i++) drive_idle(1'b0, '0, '0, vreg_addr_t'(i));
        report_test("reset", N_RESET, errs);

        // odd items read the address being loaded, through the bypass
        errs = error_count;
        for (int i = 0; i < N_LOADS; i++) begin
            r = next_random();
            drive_idle(r[4] | i[0], r[3:0], {next_random(), next_random()},
                       i[0] ? r[3:0] : r[11:8]);
        end
        report_test("loads", N_LOADS, errs);

        errs = error_count;
        for (int i = 0; i < N_UNMASKED; i++) begin
            r   = next_random();
            vd  = (i < 2) ? vreg_addr_t'(15 - i) : r[3:0];
            grp = (i < 2) ? vgroup_t'(3) : r[5:4];
            run_op(random_op(), vd, r[11:8], r[15:12], grp, 1'b0, 1'b0, 1'b0);
            read_group(vd, grp);
        end
        report_test("unmasked ops", N_UNMASKED, errs);

        // fresh v0 before each op, sources overlap the destination group
        errs = error_count;
        for (int i = 0; i < N_MASKED; i++) begin
            drive_idle(1'b1, '0, {next_random(), next_random()}, '0);
            r  = next_random();
            vd = r[3:0];
            run_op(random_op(), vd, vd + vreg_addr_t'(r[9:8]), vd - vreg_addr_t'(r[11:10]),
                   r[5:4], 1'b1, 1'b0, 1'b0);
            read_group(vd, r[5:4]);
        end
        report_test("masked ops", N_MASKED, errs);

        errs = error_count;
        for (int i = 0; i < N_HAZARD; i++) begin
            r = next_random();
            run_op(random_op(), r[3:0], r[11:8], r[15:12], r[5:4], r[6], 1'b1, 1'b0);
            // loads land anywhere in the four registers from the base
            read_group(r[3:0], 2'd3);
        end
        report_test("load hazards", N_HAZARD, errs);

        errs = error_count;
        for (int i = 0; i < N_BUSY; i++) begin
            r = next_random();
            run_op(random_op(), r[3:0], r[11:8], r[15:12], r[5:4], r[6], 1'b0, 1'b1);
            read_group(r[3:0], r[5:4]);
        end
        report_test("issue while busy", N_BUSY, errs);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // bounds the whole run
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
vec_pkg.sv
vec_ctrl_if.sv
vec_regfile.sv
vec_alu.sv
vec_group_counter.sv
vec_issue_fsm.sv
vec_unit_top.sv
tb_clkgen.sv
tb_vec_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the vector lane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_vec_unit -Mdir obj_dir

output=$(./obj_dir/Vtb_vec_unit)
echo "$output"

if grep -qx "Testbench passed" <<< "$output"; then
    exit 0
fi
exit 1
